/* all.f */
+incdir+verilog
verilog/issue_pkg.sv
verilog/fetch_queue.sv
verilog/instr_decoder.sv
verilog/dest_tracker.sv
verilog/hazard.sv
verilog/issue_port.sv
verilog/issue_stage_top.sv
test/issue_tb.sv

/* Makefile */
# Verilator build and run for the decode-and-issue stage

VERILATOR ?= verilator
TOP       ?= issue_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verilog/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Test passed" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/issue_tb.sv */
/*
 * Testbench for the decode-and-issue stage
 * Random RV32I stream, upstream and downstream credit models
 * Slot-by-slot reference model with hazard prediction, watchdog
 */

`default_nettype none

`include "issue_defines.svh"

module issue_tb import issue_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_INSTR         = 400;
  localparam int WATCHDOG_CYCLES = N_INSTR * 40;

  logic        clk;
  logic        rst;
  logic        in_valid;
  instr_word_u in_word;
  logic        in_credit;
  logic        out_valid;
  issue_slot_t out_slot;
  logic        out_credit;

  int          seed = 32'hc908_1533;
  logic [6:0]  opc_table [10];
  logic [31:0] exp_q [$];
  dest_rec_t   exp_id_ex;
  dest_rec_t   exp_ex_mem;
  int          sent = 0;
  int          issued = 0;
  int          up_credits = `FQ_DEPTH;
  int          outstanding = 0;
  int          cycle = 0;
  int          first_in_cycle = -1;
  int          first_out_cycle = -1;
  int          load_use_cnt = 0;
  int          branch_cnt = 0;
  logic        reset_seen = 1'b0;

  issue_stage_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_word    (in_word),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_slot   (out_slot),
    .out_credit (out_credit)
  );

  //////////////////////////////////////////////////////////////////////
  // Error reporting and reference rules
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
    $display("ERR %s expected %0h actual %0h", name, exp, act);
    $display("Test failed");
    $fatal(1, "first mismatch at cycle %0d", cycle);
  endtask

  task automatic abort_run(input string what);
    $display("Error at cycle %0d: %s", cycle, what);
    $display("Test failed");
    $fatal(1, "first error at cycle %0d", cycle);
  endtask

  // Control flags per opcode in the order memread regwrite branch alusrc jalr
  function automatic ctrl_t ref_ctrl(input logic [6:0] opc);
    logic [4:0] f;
    case (opc)
      `OPC_LOAD:   f = 5'b11010;
      `OPC_OP_IMM: f = 5'b01010;
      `OPC_LUI:    f = 5'b01010;
      `OPC_STORE:  f = 5'b00010;
      `OPC_OP:     f = 5'b01000;
      `OPC_BRANCH: f = 5'b00100;
      `OPC_JAL:    f = 5'b01000;
      `OPC_JALR:   f = 5'b01101;
      default:     f = 5'b00000;
    endcase
    return ctrl_t'(f);
  endfunction

  // Returns {branch stall, load-use stall} against the two older slots
  function automatic logic [1:0] stall_causes(input logic [31:0] w, input ctrl_t c,
                                              input dest_rec_t older1,
                                              input dest_rec_t older2);
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       rs2_read;
    logic       hit1;
    logic       hit2;
    rs1      = w[19:15];
    rs2      = w[24:20];
    // Immediate forms and JALR do not read rs2
    rs2_read = !c.alusrc && !c.jalr;
    hit1 = (older1.rd != 5'd0) && ((rs1 == older1.rd) || (rs2_read && rs2 == older1.rd));
    hit2 = (older2.rd != 5'd0) && ((rs1 == older2.rd) || (rs2_read && rs2 == older2.rd));
    return {c.branch && ((hit1 && older1.regwrite) || (hit2 && older2.memread)),
            hit1 && older1.memread};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Clock, reset, end of run
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    // Eight known opcodes plus AUIPC and SYSTEM as unknown ones
    opc_table = '{`OPC_LOAD, `OPC_STORE, `OPC_OP_IMM, `OPC_OP, `OPC_BRANCH,
                  `OPC_JAL, `OPC_JALR, `OPC_LUI, 7'b0010111, 7'b1110011};
    exp_id_ex  = '0;
    exp_ex_mem = '0;
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_word    = '0;
    out_credit = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    wait (issued == N_INSTR && up_credits == `FQ_DEPTH);
    // Any extra slot in the quiet period hits the empty model queue
    repeat (10) @(posedge clk);
    assert (up_credits == `FQ_DEPTH)
      else stop_on_mismatch("fetch_credits", `FQ_DEPTH, up_credits);
    assert (load_use_cnt > 0) else abort_run("no load-use stall was exercised");
    assert (branch_cnt > 0) else abort_run("no branch stall was exercised");
    $display("Issued %0d instructions, %0d load-use bubbles, %0d branch bubbles",
             issued, load_use_cnt, branch_cnt);
    $display("Test passed");
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, %0d of %0d instructions issued",
             WATCHDOG_CYCLES, issued, N_INSTR);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////////////////////////
  // Upstream fetch unit and downstream execute stage
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : drive_inputs
    logic [31:0] rnd;
    logic [31:0] word;
    int          idx;
    if (!rst) begin
      rnd = $random(seed);
      // Send on a spare credit three times out of four
      if (sent < N_INSTR && up_credits > 0 && rnd[9:8] != 2'b00) begin
        idx  = $unsigned($random(seed)) % 10;
        // Registers limited to x0..x3 so dependencies are frequent
        word = {rnd[31:25], 3'd0, rnd[1:0], 3'd0, rnd[3:2], rnd[6:4],
                3'd0, rnd[11:10], opc_table[idx]};
        in_valid <= 1'b1;
        in_word  <= instr_word_u'(word);
        exp_q.push_back(word);
        up_credits--;
        sent++;
      end else begin
        in_valid <= 1'b0;
      end
      // Return one held credit after a random delay
      if (outstanding > 0 && rnd[12]) begin
        out_credit <= 1'b1;
        outstanding--;
      end else begin
        out_credit <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output monitor and slot checks
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : check_outputs
    logic [31:0] head;
    ctrl_t       c;
    logic [1:0]  cause;
    logic        stall;
    dest_rec_t   rec;
    cycle++;
    if (!rst) begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        assert (!out_valid && !in_credit)
          else abort_run("out_valid or in_credit high right after reset");
      end
      if (in_credit) up_credits++;
      if (in_valid && first_in_cycle < 0) first_in_cycle = cycle;
      if (out_valid) begin
        // Empty pipeline and free credits give the minimum latency
        if (first_out_cycle < 0) begin
          first_out_cycle = cycle;
          assert (cycle - first_in_cycle == 2)
            else stop_on_mismatch("first_latency", 32'd2, 32'(cycle - first_in_cycle));
        end
        assert (outstanding < `OUT_CREDITS)
          else abort_run("slot issued while execute stage granted no credit");
        outstanding++;
        assert (exp_q.size() > 0) else abort_run("slot issued with no word pending");
        head  = exp_q[0];
        c     = ref_ctrl(head[6:0]);
        cause = stall_causes(head, c, exp_id_ex, exp_ex_mem);
        stall = |cause;
        assert (out_slot.bubble == stall)
          else stop_on_mismatch("bubble", {31'd0, stall}, {31'd0, out_slot.bubble});
        assert (out_slot.instr.word == head)
          else stop_on_mismatch("word", head, out_slot.instr.word);
        assert (out_slot.instr.ctrl == c)
          else stop_on_mismatch("ctrl", {27'd0, c}, {27'd0, out_slot.instr.ctrl});
        assert (out_slot.instr.rs1 == head[19:15])
          else stop_on_mismatch("rs1", {27'd0, head[19:15]}, {27'd0, out_slot.instr.rs1});
        assert (out_slot.instr.rs2 == head[24:20])
          else stop_on_mismatch("rs2", {27'd0, head[24:20]}, {27'd0, out_slot.instr.rs2});
        assert (out_slot.instr.rd == head[11:7])
          else stop_on_mismatch("rd", {27'd0, head[11:7]}, {27'd0, out_slot.instr.rd});
        // Immediate for alusrc forms, else the rs2 index
        if (c.alusrc) begin
          assert (out_slot.instr.src2 == head[31:20])
            else stop_on_mismatch("src2_imm", {20'd0, head[31:20]},
                                  {20'd0, out_slot.instr.src2});
        end else begin
          assert (out_slot.instr.src2 == {7'd0, head[24:20]})
            else stop_on_mismatch("src2_reg", {27'd0, head[24:20]},
                                  {20'd0, out_slot.instr.src2});
        end
        // Bubble enters the pipeline as an empty record
        rec = '0;
        if (!stall) begin
          rec.rd       = head[11:7];
          rec.memread  = c.memread;
          rec.regwrite = c.regwrite;
        end
        exp_ex_mem = exp_id_ex;
        exp_id_ex  = rec;
        if (stall) begin
          if (cause[0]) load_use_cnt++;
          else branch_cnt++;
        end else begin
          head = exp_q.pop_front();
          issued++;
        end
      end
    end
  end

endmodule : issue_tb

`default_nettype wire

/* verilog/issue_stage_top.sv */
/*
 * Decode-and-issue stage top level
 * Fetch queue, decoder, destination tracker, hazard block, issue port
 */

`default_nettype none

module issue_stage_top import issue_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  input  instr_word_u in_word,
  output logic        in_credit,
  output logic        out_valid,
  output issue_slot_t out_slot,
  input  logic        out_credit
);

  logic        head_valid;
  instr_word_u head_word;
  dec_instr_t  dec;
  logic        zero1;
  logic        zero2;
  logic        zero3;
  logic        zero4;
  dest_rec_t   id_ex_rec;
  dest_rec_t   ex_mem_rec;
  logic        hz;
  logic        send;
  logic        pop;

  // Input side
  fetch_queue fetch_queue_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_word    (in_word),
    .pop        (pop),
    .head_valid (head_valid),
    .head_word  (head_word),
    .in_credit  (in_credit)
  );

  instr_decoder instr_decoder_i (
    .head_word (head_word),
    .dec       (dec)
  );

  dest_tracker dest_tracker_i (
    .clk        (clk),
    .rst        (rst),
    .send       (send),
    .hz         (hz),
    .dec        (dec),
    .zero1      (zero1),
    .zero2      (zero2),
    .zero3      (zero3),
    .zero4      (zero4),
    .id_ex_rec  (id_ex_rec),
    .ex_mem_rec (ex_mem_rec)
  );

  // Head instruction plays the IF/ID role
  hazard hazard_i (
    .zero1          (zero1),
    .zero2          (zero2),
    .zero3          (zero3),
    .zero4          (zero4),
    .id_ex_memread  (id_ex_rec.memread),
    .id_ex_regwrite (id_ex_rec.regwrite),
    .ex_mem_memread (ex_mem_rec.memread),
    .if_id_branch   (dec.ctrl.branch),
    .if_id_alusrc   (dec.ctrl.alusrc),
    .if_id_jalr     (dec.ctrl.jalr),
    .hz             (hz)
  );

  // Output side
  issue_port issue_port_i (
    .clk        (clk),
    .rst        (rst),
    .head_valid (head_valid),
    .hz         (hz),
    .dec        (dec),
    .out_credit (out_credit),
    .send       (send),
    .pop        (pop),
    .out_valid  (out_valid),
    .out_slot   (out_slot)
  );

endmodule : issue_stage_top

`default_nettype wire

/* verilog/issue_port.sv */
/*
 * Output-side credit counter and advance decision
 * Registered issue slot toward the execute stage
 */

`default_nettype none

`include "issue_defines.svh"

module issue_port import issue_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        head_valid,
  input  logic        hz,
  input  dec_instr_t  dec,
  input  logic        out_credit,
  output logic        send,
  output logic        pop,
  output logic        out_valid,
  output issue_slot_t out_slot
);

  localparam int CRED_W = $clog2(`OUT_CREDITS + 1);

  logic [CRED_W-1:0] credit;

  ////////////////////////////////////////////////////////////////////
  // Advance decision
  ////////////////////////////////////////////////////////////////////

  // A slot leaves when there is a head and a credit to spend
  assign send = head_valid && (credit != '0);
  // Head is consumed only when the slot is not a bubble
  assign pop  = send && !hz;

  ////////////////////////////////////////////////////////////////////
  // Credits and output register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      credit    <= CRED_W'(`OUT_CREDITS);
      out_valid <= 1'b0;
    end else begin
      case ({send, out_credit})
        2'b10:   credit <= credit - 1'b1;
        2'b01:   credit <= credit + 1'b1;
        default: credit <= credit;
      endcase
      out_valid <= send;
    end
  end

  // Bubble slots still carry the decoded head for observation
  always_ff @(posedge clk) begin
    if (send) begin
      out_slot.bubble <= hz;
      out_slot.instr  <= dec;
    end
  end

endmodule : issue_port

`default_nettype wire

/* verilog/hazard.sv */
/*
 * Stall decision for load-use and branch hazards
 */

`default_nettype none

module hazard (
  input  logic zero1,
  input  logic zero2,
  input  logic zero3,
  input  logic zero4,
  input  logic id_ex_memread,
  input  logic id_ex_regwrite,
  input  logic ex_mem_memread,
  input  logic if_id_branch,
  input  logic if_id_alusrc,
  input  logic if_id_jalr,
  output logic hz
);

  logic rs2_live;
  logic dep_id_ex;
  logic dep_ex_mem;
  logic load_use;
  logic branch_dep;

  // rs2 is not a source for immediate forms or JALR
  assign rs2_live = !(if_id_alusrc || if_id_jalr);

  // Dependency on the instruction one slot ahead
  assign dep_id_ex  = zero1 || (zero2 && rs2_live);
  // Dependency on the instruction two slots ahead
  assign dep_ex_mem = zero3 || (zero4 && rs2_live);

  assign load_use   = dep_id_ex && id_ex_memread;
  // Branches resolve early, so they also wait on ALU results and older loads
  assign branch_dep = if_id_branch &&
                      ((dep_id_ex && id_ex_regwrite) || (dep_ex_mem && ex_mem_memread));

  assign hz = load_use || branch_dep;

endmodule : hazard

`default_nettype wire

/* verilog/dest_tracker.sv */
/*
 * Destinations of the two instructions in flight (ID/EX, EX/MEM)
 * Source against destination match flags for the hazard block
 */

`default_nettype none

module dest_tracker import issue_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       send,
  input  logic       hz,
  input  dec_instr_t dec,
  output logic       zero1,
  output logic       zero2,
  output logic       zero3,
  output logic       zero4,
  output dest_rec_t  id_ex_rec,
  output dest_rec_t  ex_mem_rec
);

  dest_rec_t cur_rec;

  // Record of the head instruction is empty when a bubble goes out
  always_comb begin
    cur_rec = '0;
    if (!hz) begin
      cur_rec.rd       = dec.rd;
      cur_rec.memread  = dec.ctrl.memread;
      cur_rec.regwrite = dec.ctrl.regwrite;
    end
  end

  // Shift only when a slot leaves so a credit stall freezes both
  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex_rec  <= '0;
      ex_mem_rec <= '0;
    end else if (send) begin
      ex_mem_rec <= id_ex_rec;
      id_ex_rec  <= cur_rec;
    end
  end

  // x0 never creates a dependency
  assign zero1 = (id_ex_rec.rd != 5'd0) && (dec.rs1 == id_ex_rec.rd);
  assign zero2 = (id_ex_rec.rd != 5'd0) && (dec.rs2 == id_ex_rec.rd);
  assign zero3 = (ex_mem_rec.rd != 5'd0) && (dec.rs1 == ex_mem_rec.rd);
  assign zero4 = (ex_mem_rec.rd != 5'd0) && (dec.rs2 == ex_mem_rec.rd);

endmodule : dest_tracker

`default_nettype wire

/* verilog/instr_decoder.sv */
/*
 * Combinational decode of the queue head
 * Register indices, second operand and control flags
 */

`default_nettype none

`include "issue_defines.svh"

module instr_decoder import issue_pkg::*; (
  input  instr_word_u head_word,
  output dec_instr_t  dec
);

  ctrl_t ctrl;

  // Opcode to control flags
  always_comb begin
    ctrl = '0;
    case (head_word.r_fmt.opcode)
      `OPC_LOAD: begin
        ctrl.memread  = 1'b1;
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
      end
      `OPC_OP_IMM, `OPC_LUI: begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
      end
      `OPC_STORE:  ctrl.alusrc   = 1'b1;
      `OPC_OP:     ctrl.regwrite = 1'b1;
      `OPC_BRANCH: ctrl.branch   = 1'b1;
      `OPC_JAL:    ctrl.regwrite = 1'b1;
      `OPC_JALR: begin
        ctrl.regwrite = 1'b1;
        ctrl.branch   = 1'b1;
        ctrl.jalr     = 1'b1;
      end
      // Unknown opcodes decode as a no-op
      default: ctrl = '0;
    endcase
  end

  // Register fields sit at the same place in both views
  assign dec.rs1  = head_word.r_fmt.rs1;
  assign dec.rs2  = head_word.r_fmt.rs2;
  assign dec.rd   = head_word.r_fmt.rd;
  // Second operand read through whichever view applies
  assign dec.src2 = ctrl.alusrc ? head_word.i_fmt.imm12 : {7'd0, head_word.r_fmt.rs2};
  assign dec.ctrl = ctrl;
  assign dec.word = head_word;

endmodule : instr_decoder

`default_nettype wire

/* verilog/fetch_queue.sv */
/*
 * Input-side instruction FIFO
 * One registered credit goes back upstream for each popped entry
 */

`default_nettype none

`include "issue_defines.svh"

module fetch_queue import issue_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  input  instr_word_u in_word,
  input  logic        pop,
  output logic        head_valid,
  output instr_word_u head_word,
  output logic        in_credit
);

  localparam int PTR_W = $clog2(`FQ_DEPTH);
  localparam int CNT_W = $clog2(`FQ_DEPTH + 1);

  // Word storage
  instr_word_u      mem [`FQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Pointer advance with wrap for non power-of-two depths
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(`FQ_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) wr_ptr <= ptr_next(wr_ptr);
      if (pop)      rd_ptr <= ptr_next(rd_ptr);
      // Upstream credits rule out overflow and a pop only comes with a valid head
      case ({in_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Credit pulse one cycle after the pop
      in_credit <= pop;
    end
  end

  assign head_valid = (count != '0);
  assign head_word  = mem[rd_ptr];

endmodule : fetch_queue

`default_nettype wire

/* verilog/issue_pkg.sv */
/*
 * Types shared by the decode-and-issue slice
 * Instruction word views, control flags, decoded instruction, issue slot
 */

`default_nettype none

package issue_pkg;

  ////////////////////////////////////////////////////////////////////
  // Instruction word
  ////////////////////////////////////////////////////////////////////

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Immediate layout where imm12 overlays funct7 and rs2
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_word_u;

  ////////////////////////////////////////////////////////////////////
  // Decode results
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic memread;
    logic regwrite;
    logic branch;
    logic alusrc;
    logic jalr;
  } ctrl_t;

  typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    // Immediate when alusrc, else zero-extended rs2 index
    logic [11:0] src2;
    ctrl_t       ctrl;
    logic [31:0] word;
  } dec_instr_t;

  // Destination of an instruction already issued
  typedef struct packed {
    logic [4:0] rd;
    logic       memread;
    logic       regwrite;
  } dest_rec_t;

  typedef struct packed {
    logic       bubble;
    dec_instr_t instr;
  } issue_slot_t;

endpackage : issue_pkg

`default_nettype wire

/* verilog/issue_defines.svh */
/*
 * Sizing macros for the decode-and-issue slice
 * RV32I major opcodes used by the decoder
 */

`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// Fetch queue entries and initial upstream credit count
`define FQ_DEPTH     4
// Credits granted by the execute stage after reset
`define OUT_CREDITS  3

// RV32I opcodes, bits [6:0] of the instruction word
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OP_IMM   7'b0010011
`define OPC_OP       7'b0110011
`define OPC_BRANCH   7'b1100011
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_LUI      7'b0110111

`endif
